// ==== dcache_params.svh ====
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// address split, msb to lsb: tag | index | byte offset
`define DCACHE_ADDR_W      32
`define DCACHE_WORD_W      32

// eight words of four bytes per line
`define DCACHE_LINE_WORDS  8
`define DCACHE_OFFSET_W    5   // word select is bits 4:2

`define DCACHE_INDEX_W     7   // 128 sets
`define DCACHE_TAG_W       20  // upper address bits

`define DCACHE_WAYS        2

`endif

// ==== dcache_pkg.sv ====
`default_nettype none

`include "dcache_params.svh"

package dcache_pkg;

    // plain op code, sampled as a level every cycle
    typedef enum logic [1:0] {
        OP_IDLE   = 2'd0,
        OP_LOAD   = 2'd1,
        OP_STORE  = 2'd2,
        OP_REFILL = 2'd3
    } dcache_op_t;

    typedef logic [`DCACHE_WORD_W-1:0]   word_t;
    typedef logic [`DCACHE_TAG_W-1:0]    tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0]  index_t;

    // word 0 sits in the low bits
    typedef word_t [`DCACHE_LINE_WORDS-1:0] line_t;

    typedef logic [`DCACHE_WORD_W/8-1:0] byte_en_t;  // one strobe per byte

endpackage

`default_nettype wire

// ==== dcache_way_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dcache_way_if;

    // read results of one way, valid one cycle after addr
    dcache_pkg::tag_t  rtag;
    logic              rvalid;
    logic              rdirty;
    dcache_pkg::line_t rline;

    logic              hit;  // tag match for this way, from the selector

    modport way (
        output rtag,
        output rvalid,
        output rdirty,
        output rline,
        input  hit
    );

    modport sel (
        input  rtag,
        input  rvalid,
        input  rdirty,
        input  rline,
        output hit
    );

endinterface

`default_nettype wire

// ==== dcache_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_ram #(
    parameter type T     = logic,
    parameter int  DEPTH = 1 << `DCACHE_INDEX_W
) (
    input  logic               clk,
    input  logic               we,
    input  dcache_pkg::index_t waddr,
    input  T                   wdata,
    input  dcache_pkg::index_t raddr,
    output T                   rdata
);

    T mem [DEPTH];

    // block ram style, registered read port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];  // same-set write returns old data
    end

endmodule

`default_nettype wire

// ==== dcache_flag_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_flag_ram #(
    parameter int DEPTH = 1 << `DCACHE_INDEX_W
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               we,
    input  dcache_pkg::index_t waddr,
    input  logic               wdata,
    input  dcache_pkg::index_t raddr,
    output logic               rdata
);

    logic [DEPTH-1:0] flags;

    // one bit per set, all clear out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
            rdata <= 1'b0;
        end else begin
            if (we) begin
                flags[waddr] <= wdata;
            end
            rdata <= flags[raddr];  // old value on a same-set write
        end
    end

endmodule

`default_nettype wire

// ==== dcache_way.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_way #(
    parameter bit WAY_ID = 1'b0
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  dcache_pkg::dcache_op_t    op,
    input  logic [`DCACHE_ADDR_W-1:0] addr,
    input  dcache_pkg::word_t         store_data,
    input  dcache_pkg::byte_en_t      byte_en,
    input  dcache_pkg::line_t         refill_line,
    input  logic                      select_way,
    dcache_way_if.way                 rd
);

    localparam int WORD_LSB = $clog2(`DCACHE_WORD_W / 8);
    localparam int WSEL_W   = $clog2(`DCACHE_LINE_WORDS);

    dcache_pkg::index_t            idx;
    logic [WSEL_W-1:0]             wsel;
    logic                          refill_en;
    logic                          store_en;
    dcache_pkg::word_t             merged;
    logic [`DCACHE_LINE_WORDS-1:0] word_we;
    dcache_pkg::line_t             word_wdata;
    dcache_pkg::line_t             rline;
    dcache_pkg::tag_t              rtag;
    logic                          rvalid;
    logic                          rdirty;

    assign idx  = addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign wsel = addr[WORD_LSB +: WSEL_W];

    assign refill_en = (op == dcache_pkg::OP_REFILL) && (select_way == WAY_ID);
    assign store_en  = (op == dcache_pkg::OP_STORE) && rd.hit;  // a miss writes nothing

    // merge store bytes into the word read during the lookup
    always_comb begin
        for (int b = 0; b < `DCACHE_WORD_W / 8; b++) begin
            merged[b*8 +: 8] = byte_en[b] ? store_data[b*8 +: 8] : rline[wsel][b*8 +: 8];
        end
    end

    for (genvar w = 0; w < `DCACHE_LINE_WORDS; w++) begin : g_word
        assign word_we[w]    = refill_en || (store_en && (wsel == WSEL_W'(w)) && (|byte_en));
        assign word_wdata[w] = refill_en ? refill_line[w] : merged;

        dcache_ram #(
            .T (dcache_pkg::word_t)
        ) u_data (
            .clk   (clk),
            .we    (word_we[w]),
            .waddr (idx),
            .wdata (word_wdata[w]),
            .raddr (idx),
            .rdata (rline[w])
        );
    end

    dcache_ram #(
        .T (dcache_pkg::tag_t)
    ) u_tag (
        .clk   (clk),
        .we    (refill_en),
        .waddr (idx),
        .wdata (addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W]),
        .raddr (idx),
        .rdata (rtag)
    );

    dcache_flag_ram u_valid (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (refill_en),
        .waddr  (idx),
        .wdata  (1'b1),
        .raddr  (idx),
        .rdata  (rvalid)
    );

    // refill cleans the line, a hitting store dirties it
    dcache_flag_ram u_dirty (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (refill_en || store_en),
        .waddr  (idx),
        .wdata  (store_en),
        .raddr  (idx),
        .rdata  (rdirty)
    );

    assign rd.rtag   = rtag;
    assign rd.rvalid = rvalid;
    assign rd.rdirty = rdirty;
    assign rd.rline  = rline;

endmodule

`default_nettype wire

// ==== dcache_way_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_way_select (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [`DCACHE_ADDR_W-1:0] addr,
    input  logic [`DCACHE_ADDR_W-1:0] paddr,
    input  logic                      select_way,
    input  logic                      lru_we,
    dcache_way_if.sel                 way0,
    dcache_way_if.sel                 way1,
    output logic                      hit,
    output dcache_pkg::word_t         load_data,
    output dcache_pkg::line_t         victim_line,
    output dcache_pkg::tag_t          victim_tag,
    output logic                      victim_dirty,
    output logic                      lru
);

    localparam int WORD_LSB = $clog2(`DCACHE_WORD_W / 8);
    localparam int WSEL_W   = $clog2(`DCACHE_LINE_WORDS);

    dcache_pkg::tag_t        ptag;
    logic [WSEL_W-1:0]       pwsel;
    logic [`DCACHE_WAYS-1:0] way_hit;
    logic                    victim_way;

    assign ptag  = paddr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
    assign pwsel = paddr[WORD_LSB +: WSEL_W];

    assign way_hit[0] = way0.rvalid && (way0.rtag == ptag);
    assign way_hit[1] = way1.rvalid && (way1.rtag == ptag);

    assign way0.hit = way_hit[0];  // store enable inside each way
    assign way1.hit = way_hit[1];
    assign hit      = |way_hit;

    always_comb begin
        case (way_hit)
            2'b01:   load_data = way0.rline[pwsel];
            2'b10:   load_data = way1.rline[pwsel];
            default: load_data = way0.rline[0];  // miss
        endcase
    end

    // hit way wins, else the refill candidate
    assign victim_way   = hit ? way_hit[1] : select_way;
    assign victim_line  = victim_way ? way1.rline : way0.rline;
    assign victim_tag   = victim_way ? way1.rtag : way0.rtag;
    assign victim_dirty = victim_way ? way1.rdirty : way0.rdirty;

    // lru bit records whether way 1 took the last hit
    dcache_flag_ram u_lru (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (lru_we),
        .waddr  (paddr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W]),
        .wdata  (way_hit[1]),
        .raddr  (addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W]),
        .rdata  (lru)
    );

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  dcache_pkg::dcache_op_t    op,
    input  logic [`DCACHE_ADDR_W-1:0] addr,
    input  logic [`DCACHE_ADDR_W-1:0] paddr,
    input  dcache_pkg::word_t         store_data,
    input  dcache_pkg::byte_en_t      byte_en,
    input  dcache_pkg::line_t         refill_line,
    input  logic                      select_way,
    input  logic                      lru_we,
    output logic                      hit,
    output dcache_pkg::word_t         load_data,
    output dcache_pkg::line_t         victim_line,
    output dcache_pkg::tag_t          victim_tag,
    output logic                      victim_dirty,
    output logic                      lru
);

    dcache_way_if way0_if ();
    dcache_way_if way1_if ();

    dcache_way #(
        .WAY_ID (1'b0)
    ) u_way0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .op          (op),
        .addr        (addr),
        .store_data  (store_data),
        .byte_en     (byte_en),
        .refill_line (refill_line),
        .select_way  (select_way),
        .rd          (way0_if.way)
    );

    dcache_way #(
        .WAY_ID (1'b1)
    ) u_way1 (
        .clk         (clk),
        .arst_n      (arst_n),
        .op          (op),
        .addr        (addr),
        .store_data  (store_data),
        .byte_en     (byte_en),
        .refill_line (refill_line),
        .select_way  (select_way),
        .rd          (way1_if.way)
    );

    dcache_way_select u_sel (
        .clk          (clk),
        .arst_n       (arst_n),
        .addr         (addr),
        .paddr        (paddr),
        .select_way   (select_way),
        .lru_we       (lru_we),
        .way0         (way0_if.sel),
        .way1         (way1_if.sel),
        .hit          (hit),
        .load_data    (load_data),
        .victim_line  (victim_line),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty),
        .lru          (lru)
    );

endmodule

`default_nettype wire

// ==== dcache_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_sva (
    input logic                      clk,
    input logic                      arst_n,
    input dcache_pkg::dcache_op_t    op,
    input logic [`DCACHE_ADDR_W-1:0] addr,
    input logic [`DCACHE_ADDR_W-1:0] paddr,
    input dcache_pkg::byte_en_t      byte_en,
    input logic                      select_way,
    input logic                      way0_hit,
    input logic                      way1_hit,
    input logic                      hit,
    input dcache_pkg::line_t         victim_line
);

    int n_fail = 0;  // failed assertions so far

    // valid bits read back clear right after reset
    a_no_hit_after_reset: assert property (
        @(posedge clk) $rose(arst_n) |-> !hit
    ) else begin
        $error("hit high in the first cycle after reset");
        n_fail++;
    end

    a_single_way_hit: assert property (
        @(posedge clk) disable iff (!arst_n) !(way0_hit && way1_hit)
    ) else begin
        $error("both ways hit one lookup");
        n_fail++;
    end

    // missed store without strobes, then the same lookup one operation later
    a_missed_store_keeps_line: assert property (
        @(posedge clk) disable iff (!arst_n)
        (op == dcache_pkg::OP_STORE && !hit && byte_en == '0)
        ##2 (addr == $past(addr, 2) && paddr == $past(paddr, 2)
             && select_way == $past(select_way, 2) && !hit)
        |-> victim_line === $past(victim_line, 2)
    ) else begin
        $error("missed store changed the line");
        n_fail++;
    end

endmodule

bind dcache_top dcache_sva u_sva (
    .clk         (clk),
    .arst_n      (arst_n),
    .op          (op),
    .addr        (addr),
    .paddr       (paddr),
    .byte_en     (byte_en),
    .select_way  (select_way),
    .way0_hit    (way0_if.hit),
    .way1_hit    (way1_if.hit),
    .hit         (hit),
    .victim_line (victim_line)
);

`default_nettype wire

// ==== dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_tb;

    localparam int          CLK_PERIOD = 100;
    localparam int          N_DIRECTED = 40;  // upper bound on the directed operations
    localparam int          N_RANDOM   = 400;
    localparam int          N_SETS     = 1 << `DCACHE_INDEX_W;
    localparam int          WORD_LSB   = $clog2(`DCACHE_WORD_W / 8);
    localparam int          WSEL_W     = $clog2(`DCACHE_LINE_WORDS);
    localparam int          TIMEOUT_NS = ((N_DIRECTED + N_RANDOM) * 4 + 20) * CLK_PERIOD;
    localparam logic [31:0] SEED       = 32'hcaee_e22d;

    localparam dcache_pkg::tag_t TAG_A = 20'h1a2b3;
    localparam dcache_pkg::tag_t TAG_B = 20'h0c0de;
    localparam dcache_pkg::tag_t TAG_C = 20'h5eed1;
    localparam int               SET_A = 21;

    typedef struct packed {
        logic              hit;
        logic              hit_way;
        dcache_pkg::word_t load_data;
        logic              load_valid;
        dcache_pkg::line_t victim_line;
        dcache_pkg::tag_t  victim_tag;
        logic              victim_valid;
        logic              victim_dirty;
        logic              lru;
    } expect_t;

    logic                      clk;
    logic                      arst_n;
    dcache_pkg::dcache_op_t    op;
    logic [`DCACHE_ADDR_W-1:0] addr;
    logic [`DCACHE_ADDR_W-1:0] paddr;
    dcache_pkg::word_t         store_data;
    dcache_pkg::byte_en_t      byte_en;
    dcache_pkg::line_t         refill_line;
    logic                      select_way;
    logic                      lru_we;
    logic                      hit;
    dcache_pkg::word_t         load_data;
    dcache_pkg::line_t         victim_line;
    dcache_pkg::tag_t          victim_tag;
    logic                      victim_dirty;
    logic                      lru;

    // reference state of both ways
    dcache_pkg::tag_t  m_tag   [`DCACHE_WAYS][N_SETS];
    bit                m_valid [`DCACHE_WAYS][N_SETS];
    bit                m_dirty [`DCACHE_WAYS][N_SETS];
    dcache_pkg::line_t m_line  [`DCACHE_WAYS][N_SETS];
    bit                m_lru   [N_SETS];

    expect_t exp_res;
    logic    chk_en;
    int      n_checks;
    int      n_errors;

    dcache_top UUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .op           (op),
        .addr         (addr),
        .paddr        (paddr),
        .store_data   (store_data),
        .byte_en      (byte_en),
        .refill_line  (refill_line),
        .select_way   (select_way),
        .lru_we       (lru_we),
        .hit          (hit),
        .load_data    (load_data),
        .victim_line  (victim_line),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty),
        .lru          (lru)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [`DCACHE_ADDR_W-1:0] make_addr(input dcache_pkg::tag_t t,
                                                            input int s, input int w);
        return {t, dcache_pkg::index_t'(s), WSEL_W'(w), {WORD_LSB{1'b0}}};
    endfunction

    // expected lookup result from the model, before the op changes it
    function automatic expect_t predict_lookup(input logic [`DCACHE_ADDR_W-1:0] a,
                                               input logic sel);
        expect_t    e;
        int         s;
        logic [1:0] wh;
        logic       vw;
        s = a[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            wh[w] = m_valid[w][s] && (m_tag[w][s] == a[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W]);
        end
        e.hit          = |wh;
        e.hit_way      = wh[1];
        vw             = e.hit ? wh[1] : sel;  // victim is the hit way, else select_way
        // a miss returns word 0 of way 0
        e.load_data    = e.hit ? m_line[vw][s][a[WORD_LSB +: WSEL_W]] : m_line[0][s][0];
        e.load_valid   = e.hit || m_valid[0][s];
        e.victim_line  = m_line[vw][s];
        e.victim_tag   = m_tag[vw][s];
        e.victim_valid = m_valid[vw][s];
        e.victim_dirty = m_dirty[vw][s];
        e.lru          = m_lru[s];
        return e;
    endfunction

    task automatic update_model(input dcache_pkg::dcache_op_t o,
                                input logic [`DCACHE_ADDR_W-1:0] a,
                                input logic sel, input expect_t e);
        int s;
        int ws;
        s  = a[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
        ws = a[WORD_LSB +: WSEL_W];
        if (o == dcache_pkg::OP_STORE && e.hit) begin
            for (int b = 0; b < `DCACHE_WORD_W / 8; b++) begin
                if (byte_en[b]) begin
                    m_line[e.hit_way][s][ws][b*8 +: 8] = store_data[b*8 +: 8];
                end
            end
            m_dirty[e.hit_way][s] = 1'b1;
        end
        if (o == dcache_pkg::OP_REFILL) begin
            m_line[sel][s]  = refill_line;
            m_tag[sel][s]   = a[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
            m_valid[sel][s] = 1'b1;
            m_dirty[sel][s] = 1'b0;
        end
        if (lru_we) begin
            m_lru[s] = e.hit && e.hit_way;
        end
    endtask

    // index cycle with op idle, then the lookup cycle carrying the op
    task automatic run_op(input dcache_pkg::dcache_op_t o, input logic [`DCACHE_ADDR_W-1:0] a,
                          input logic sel, input dcache_pkg::byte_en_t be, input logic lwe);
        expect_t e;
        @(negedge clk);
        chk_en = 1'b0;
        op     = dcache_pkg::OP_IDLE;
        lru_we = 1'b0;
        addr   = a;
        paddr  = a;
        @(negedge clk);
        e          = predict_lookup(a, sel);
        op         = o;
        select_way = sel;
        byte_en    = be;
        lru_we     = lwe;
        store_data = $urandom();
        for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
            refill_line[w] = $urandom();
        end
        exp_res = e;
        chk_en  = 1'b1;
        update_model(o, a, sel, e);
    endtask

    task automatic report_mismatch(input string what, input logic [255:0] got,
                                   input logic [255:0] want);
        $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, want);
        n_errors++;
    endtask

    always @(posedge clk) begin
        if (chk_en) begin
            n_checks++;
            assert (hit === exp_res.hit)
                else report_mismatch("hit", hit, exp_res.hit);
            assert (lru === exp_res.lru)
                else report_mismatch("lru", lru, exp_res.lru);
            assert (victim_dirty === exp_res.victim_dirty)
                else report_mismatch("victim_dirty", victim_dirty, exp_res.victim_dirty);
            if (exp_res.load_valid) begin
                assert (load_data === exp_res.load_data)
                    else report_mismatch("load_data", load_data, exp_res.load_data);
            end
            if (exp_res.victim_valid) begin
                assert (victim_line === exp_res.victim_line)
                    else report_mismatch("victim_line", victim_line, exp_res.victim_line);
                assert (victim_tag === exp_res.victim_tag)
                    else report_mismatch("victim_tag", victim_tag, exp_res.victim_tag);
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not complete within %0d ns", TIMEOUT_NS);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        logic [`DCACHE_ADDR_W-1:0] a;
        dcache_pkg::tag_t          rtag;
        int                        rset;
        logic                      rsel;
        int unsigned               kind;
        clk         = 1'b0;
        arst_n      = 1'b0;
        op          = dcache_pkg::OP_IDLE;
        addr        = '0;
        paddr       = '0;
        store_data  = '0;
        byte_en     = '0;
        refill_line = '0;
        select_way  = 1'b0;
        lru_we      = 1'b0;
        chk_en      = 1'b0;
        n_checks    = 0;
        n_errors    = 0;
        void'($urandom(SEED));
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (int i = 0; i < 4; i++) begin
            run_op(dcache_pkg::OP_LOAD, $urandom(), i[0], '0, 1'b0);
        end

        // fill way 1 and walk the line, then put another tag in way 0
        run_op(dcache_pkg::OP_REFILL, make_addr(TAG_A, SET_A, 0), 1'b1, '0, 1'b0);
        for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
            run_op(dcache_pkg::OP_LOAD, make_addr(TAG_A, SET_A, w), 1'b0, '0, 1'b0);
        end
        run_op(dcache_pkg::OP_REFILL, make_addr(TAG_B, SET_A, 0), 1'b0, '0, 1'b0);

        for (int i = 0; i < 4; i++) begin
            run_op(dcache_pkg::OP_STORE, make_addr(TAG_A, SET_A, i * 2), 1'b0,
                   dcache_pkg::byte_en_t'($urandom_range(15)), 1'b0);
            run_op(dcache_pkg::OP_LOAD, make_addr(TAG_A, SET_A, i * 2), 1'b0, '0, 1'b0);
            run_op(dcache_pkg::OP_LOAD, make_addr(TAG_B, SET_A, i * 2), 1'b0, '0, 1'b0);
        end

        // stores to an absent tag
        run_op(dcache_pkg::OP_STORE, make_addr(TAG_C, SET_A, 3), 1'b0, '0, 1'b0);
        run_op(dcache_pkg::OP_LOAD, make_addr(TAG_C, SET_A, 3), 1'b0, '0, 1'b0);
        run_op(dcache_pkg::OP_STORE, make_addr(TAG_C, SET_A, 5), 1'b1,
               dcache_pkg::byte_en_t'($urandom_range(1, 15)), 1'b0);
        run_op(dcache_pkg::OP_LOAD, make_addr(TAG_C, SET_A, 5), 1'b1, '0, 1'b0);

        run_op(dcache_pkg::OP_LOAD, make_addr(TAG_A, SET_A, 1), 1'b0, '0, 1'b1);
        run_op(dcache_pkg::OP_LOAD, make_addr(TAG_B, SET_A, 1), 1'b0, '0, 1'b1);
        run_op(dcache_pkg::OP_LOAD, make_addr(TAG_B, SET_A, 2), 1'b0, '0, 1'b0);
        run_op(dcache_pkg::OP_LOAD, make_addr(TAG_C, SET_A, 0), 1'b1, '0, 1'b1);
        run_op(dcache_pkg::OP_LOAD, make_addr(TAG_C, SET_A, 0), 1'b0, '0, 1'b0);

        for (int i = 0; i < N_RANDOM; i++) begin
            rtag = TAG_A + dcache_pkg::tag_t'($urandom_range(3));
            rset = $urandom_range(15) * 8;
            rsel = $urandom_range(1);
            kind = $urandom_range(99);
            a    = make_addr(rtag, rset, $urandom_range(7));
            if (kind < 25) begin
                // keep a tag in one way of a set only
                if (m_valid[!rsel][rset] && (m_tag[!rsel][rset] == rtag)) begin
                    rsel = !rsel;
                end
                run_op(dcache_pkg::OP_REFILL, a, rsel, '0, 1'b0);
            end else if (kind < 55) begin
                run_op(dcache_pkg::OP_STORE, a, rsel,
                       dcache_pkg::byte_en_t'($urandom_range(15)), $urandom_range(1));
            end else begin
                run_op(dcache_pkg::OP_LOAD, a, rsel, '0, $urandom_range(1));
            end
        end

        @(negedge clk);
        chk_en = 1'b0;
        op     = dcache_pkg::OP_IDLE;
        lru_we = 1'b0;
        @(negedge clk);
        $display("summary: %0d lookups checked, %0d errors, %0d assertion failures",
                 n_checks, n_errors, UUT.u_sva.n_fail);
        if (n_errors == 0 && UUT.u_sva.n_fail == 0 && n_checks > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dcache_top.f ====
+incdir+.
dcache_pkg.sv
dcache_way_if.sv
dcache_ram.sv
dcache_flag_ram.sv
dcache_way.sv
dcache_way_select.sv
dcache_top.sv
dcache_sva.sv
dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - dcache_pkg.sv
      - dcache_way_if.sv
      - dcache_ram.sv
      - dcache_flag_ram.sv
      - dcache_way.sv
      - dcache_way_select.sv
      - dcache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - dcache_sva.sv
      - dcache_tb.sv
